/* hw/elevator_pkg.sv */
// Elevator floor logic definitions
`default_nettype none

package elevator_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Building size and request storage
    ////////////////////////////////////////////////////////////////////////////

    // Eleven floors, floor 1 is encoded as 0
    localparam int num_floors = 11;

    // Entries in the request FIFO, also the initial credit count
    localparam int queue_depth = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Floor number
    typedef logic [3:0] floor_t;

    // One bit per floor, used for buttons and lamps
    typedef logic [num_floors-1:0] floor_mask_t;

    // Wide enough to hold queue_depth
    typedef logic [3:0] credit_t;

endpackage

`default_nettype wire

/* hw/request_latch.sv */
// Button latch and request enqueue
`default_nettype none
`timescale 1ns/10ps

module request_latch (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire elevator_pkg::floor_mask_t call_buttons,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire elevator_pkg::floor_t current_floor,
    input  wire                       power_switch,
    input  wire                       emergency_btn,
    input  wire                       arrive_valid,
    input  wire elevator_pkg::floor_t arrive_floor,
    input  wire                       credit_return,
    output logic                      push_valid,
    output elevator_pkg::floor_t      push_floor,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights
);

    elevator_pkg::floor_mask_t current_mask;
    elevator_pkg::floor_mask_t arrive_mask;
    elevator_pkg::floor_mask_t push_mask;
    elevator_pkg::floor_mask_t call_accept;
    elevator_pkg::floor_mask_t panel_accept;
    elevator_pkg::floor_mask_t new_floors;
    elevator_pkg::floor_mask_t pending;
    elevator_pkg::credit_t     credits;
    logic                      accept_en;

    // Priority pick of the lowest set bit
    function automatic elevator_pkg::floor_t lowest_floor(input elevator_pkg::floor_mask_t mask);
        elevator_pkg::floor_t idx;
        idx = '0;
        for (int i = elevator_pkg::num_floors - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = elevator_pkg::floor_t'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Press qualification
    ////////////////////////////////////////////////////////////////////////////

    assign accept_en    = power_switch && !emergency_btn;
    assign current_mask = elevator_pkg::floor_mask_t'(1) << current_floor;
    assign arrive_mask  = arrive_valid ? (elevator_pkg::floor_mask_t'(1) << arrive_floor) : '0;

    // Not at the car's floor, and that lamp not already lit
    assign call_accept  = accept_en ? (call_buttons & ~call_lights & ~current_mask) : '0;
    assign panel_accept = accept_en ? (panel_buttons & ~panel_lights & ~current_mask) : '0;

    // Only a floor with both lamps dark becomes a new queue entry
    assign new_floors = (call_accept | panel_accept) & ~(call_lights | panel_lights);

    // One push per cycle while a credit is held
    assign push_valid = power_switch && (pending != '0) && (credits != '0);
    assign push_floor = lowest_floor(pending);
    assign push_mask  = push_valid ? (elevator_pkg::floor_mask_t'(1) << push_floor) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Lamps, pending mask and credits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
            pending      <= '0;
            credits      <= elevator_pkg::credit_t'(elevator_pkg::queue_depth);
        end else if (!power_switch) begin
            call_lights  <= '0;
            panel_lights <= '0;
            pending      <= '0;
            credits      <= elevator_pkg::credit_t'(elevator_pkg::queue_depth);
        end else begin
            call_lights  <= (call_lights | call_accept) & ~arrive_mask;
            panel_lights <= (panel_lights | panel_accept) & ~arrive_mask;
            pending      <= ((pending & ~push_mask) | new_floors) & ~arrive_mask;
            // Returned credit and spent credit may land on the same edge
            credits      <= credits + elevator_pkg::credit_t'(credit_return)
                                    - elevator_pkg::credit_t'(push_valid);
        end
    end

endmodule

`default_nettype wire

/* hw/request_queue.sv */
// Floor request FIFO
`default_nettype none
`timescale 1ns/10ps

module request_queue #(
    parameter int depth = elevator_pkg::queue_depth
) (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       power_switch,
    input  wire                       push_valid,
    input  wire elevator_pkg::floor_t push_floor,
    input  wire                       pop,
    output logic                      head_valid,
    output elevator_pkg::floor_t      head_floor,
    output logic                      credit_return
);

    localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    elevator_pkg::floor_t entries [depth];

    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;
    logic               do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        next_ptr = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head_floor = entries[rd_ptr];

    // Entry released and credit handed back in the same cycle
    assign do_pop        = pop && head_valid;
    assign credit_return = do_pop;

    // Storage only, no reset needed
    always_ff @(posedge clock) begin
        if (push_valid) begin
            entries[wr_ptr] <= push_floor;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (!power_switch) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push_valid && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push_valid) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/dispatch_control.sv */
// Dispatch controller
`default_nettype none
`timescale 1ns/10ps

module dispatch_control (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       head_valid,
    input  wire elevator_pkg::floor_t head_floor,
    input  wire elevator_pkg::floor_t current_floor,
    input  wire                       elevator_moving,
    input  wire                       power_switch,
    input  wire                       emergency_btn,
    input  wire                       door_open_btn,
    input  wire                       door_close_btn,
    output logic                      pop,
    output logic                      arrive_valid,
    output elevator_pkg::floor_t      arrive_floor,
    output elevator_pkg::floor_t      target_floor,
    output logic                      direction_up,
    output logic                      activate_elevator,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    logic                 busy;
    elevator_pkg::floor_t target;
    logic                 car_stopped;

    assign car_stopped = !elevator_moving && power_switch;

    ////////////////////////////////////////////////////////////////////////////
    // Request take-over and arrival
    ////////////////////////////////////////////////////////////////////////////

    // Idle controller takes the oldest request
    assign pop = !busy && head_valid && power_switch && !emergency_btn;

    // Car parked on the held target
    assign arrive_valid = busy && car_stopped && (current_floor == target);
    assign arrive_floor = target;

    assign target_floor = target;
    assign direction_up = (target > current_floor);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy              <= 1'b0;
            target            <= '0;
            activate_elevator <= 1'b0;
        end else if (!power_switch) begin
            busy              <= 1'b0;
            target            <= '0;
            activate_elevator <= 1'b0;
        end else if (pop) begin
            busy              <= 1'b1;
            target            <= head_floor;
            activate_elevator <= 1'b1;
        end else if (arrive_valid) begin
            busy              <= 1'b0;
            activate_elevator <= 1'b0;
        end else begin
            // Held low during an emergency, target kept
            activate_elevator <= busy && !emergency_btn;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Door permissions
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= door_open_btn && car_stopped;
            door_close_allowed <= door_close_btn && car_stopped;
        end
    end

endmodule

`default_nettype wire

/* hw/floor_logic_top.sv */
// Elevator floor logic top level
`default_nettype none
`timescale 1ns/10ps

module floor_logic_top (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire elevator_pkg::floor_mask_t call_buttons,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire                       door_open_btn,
    input  wire                       door_close_btn,
    input  wire                       emergency_btn,
    input  wire                       power_switch,
    input  wire elevator_pkg::floor_t current_floor,
    input  wire                       elevator_moving,
    output elevator_pkg::floor_t      target_floor,
    output logic                      direction_up,
    output logic                      activate_elevator,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights
);

    // Latch to FIFO
    logic                 push_valid;
    elevator_pkg::floor_t push_floor;
    logic                 credit_return;

    // FIFO to dispatch
    logic                 head_valid;
    elevator_pkg::floor_t head_floor;
    logic                 pop;

    // Dispatch back to latch
    logic                 arrive_valid;
    elevator_pkg::floor_t arrive_floor;

    request_latch latch0 (
        .clock         (clock),
        .reset_n       (reset_n),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .current_floor (current_floor),
        .power_switch  (power_switch),
        .emergency_btn (emergency_btn),
        .arrive_valid  (arrive_valid),
        .arrive_floor  (arrive_floor),
        .credit_return (credit_return),
        .push_valid    (push_valid),
        .push_floor    (push_floor),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights)
    );

    request_queue #(
        .depth (elevator_pkg::queue_depth)
    ) queue0 (
        .clock         (clock),
        .reset_n       (reset_n),
        .power_switch  (power_switch),
        .push_valid    (push_valid),
        .push_floor    (push_floor),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_floor    (head_floor),
        .credit_return (credit_return)
    );

    dispatch_control dispatch0 (
        .clock              (clock),
        .reset_n            (reset_n),
        .head_valid         (head_valid),
        .head_floor         (head_floor),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .pop                (pop),
        .arrive_valid       (arrive_valid),
        .arrive_floor       (arrive_floor),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

/* bench/floor_logic_properties.sv */
// Request path assertions
`default_nettype none
`timescale 1ns/10ps

module floor_logic_properties (
    input wire                        clock,
    input wire                        reset_n,
    input wire elevator_pkg::credit_t credits,
    input wire [$clog2(elevator_pkg::queue_depth + 1)-1:0] queue_count,
    input wire                        push_valid,
    input wire                        emergency_btn,
    input wire                        activate_elevator
);

    // Credit counter stays within the FIFO depth
    credit_bound: assert property (
        @(posedge clock) disable iff (!reset_n)
        int'(credits) <= elevator_pkg::queue_depth
    ) else $error("credit count %0d above FIFO depth", credits);

    // A credit spent on a push always stands for a free FIFO entry
    push_needs_credit: assert property (
        @(posedge clock) disable iff (!reset_n)
        push_valid |-> (int'(queue_count) < elevator_pkg::queue_depth)
    ) else $error("push issued with no free FIFO entry");

    // Emergency drops activate by the next cycle
    emergency_stops_car: assert property (
        @(posedge clock) disable iff (!reset_n)
        $past(emergency_btn) |-> !activate_elevator
    ) else $error("activate high after emergency");

endmodule

// Observes the latch credits, the FIFO occupancy and the dispatch outputs
bind floor_logic_top floor_logic_properties props0 (
    .clock             (clock),
    .reset_n           (reset_n),
    .credits           (latch0.credits),
    .queue_count       (queue0.count),
    .push_valid        (push_valid),
    .emergency_btn     (emergency_btn),
    .activate_elevator (activate_elevator)
);

`default_nettype wire

/* bench/floor_logic_tb.sv */
// Floor logic testbench
`default_nettype none
`timescale 1ns/10ps

module floor_logic_tb;

    localparam int num_tests  = 6;
    localparam int test_bound = 400;
    localparam int wait_bound = 40;

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::floor_mask_t call_buttons;
    elevator_pkg::floor_mask_t panel_buttons;
    logic                      door_open_btn;
    logic                      door_close_btn;
    logic                      emergency_btn;
    logic                      power_switch;
    elevator_pkg::floor_t      current_floor;
    logic                      elevator_moving;
    elevator_pkg::floor_t      target_floor;
    logic                      direction_up;
    logic                      activate_elevator;
    logic                      door_open_allowed;
    logic                      door_close_allowed;
    elevator_pkg::floor_mask_t call_lights;
    elevator_pkg::floor_mask_t panel_lights;

    int          errors;
    int          checks;
    string       test_name;
    logic [31:0] rng_state;

    floor_logic_top dut0 (
        .clock              (clock),
        .reset_n            (reset_n),
        .call_buttons       (call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .emergency_btn      (emergency_btn),
        .power_switch       (power_switch),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights)
    );

    always #10 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Floors count from 1 outside and from 0 on the ports
    function automatic elevator_pkg::floor_mask_t floor_bit(input int floor_no);
        return elevator_pkg::floor_mask_t'(1) << (floor_no - 1);
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("CHECK FAILED %s (%s): expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    // Buttons held for one sampling edge
    task automatic press(input elevator_pkg::floor_mask_t calls,
                         input elevator_pkg::floor_mask_t panels);
        call_buttons  = calls;
        panel_buttons = panels;
        @(negedge clock);
        call_buttons  = '0;
        panel_buttons = '0;
    endtask

    task automatic wait_activate(output bit seen);
        int waited;
        waited = 0;
        while (!activate_elevator && waited < wait_bound) begin
            @(negedge clock);
            waited++;
        end
        seen = activate_elevator;
        checks++;
        assert (seen) else begin
            errors++;
            $display("%s: activate_elevator did not rise within %0d cycles",
                     test_name, wait_bound);
        end
    endtask

    // Car model that travels a random time and stops at the target
    task automatic serve_request(input int expected_floor, input bit expected_up);
        bit                   seen;
        int                   travel;
        int                   waited;
        elevator_pkg::floor_t target;
        wait_activate(seen);
        if (seen) begin
            target = target_floor;
            check_value("target floor", expected_floor - 1, int'(target));
            check_value("direction up", int'(expected_up), int'(direction_up));
            rng_state       = xorshift32(rng_state);
            travel          = 1 + int'(rng_state % 4);
            elevator_moving = 1'b1;
            repeat (travel) @(negedge clock);
            current_floor   = target;
            elevator_moving = 1'b0;
            waited = 0;
            while (activate_elevator && waited < wait_bound) begin
                @(negedge clock);
                waited++;
            end
            check_value("activate after arrival", 0, int'(activate_elevator));
            check_value("lamps at served floor", 0,
                        int'(call_lights[target] | panel_lights[target]));
        end
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_value("activate while idle", 0, int'(activate_elevator));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        test_name = "reset state";
        check_value("call lights", 0, int'(call_lights));
        check_value("panel lights", 0, int'(panel_lights));
        check_value("activate", 0, int'(activate_elevator));
        check_value("door open", 0, int'(door_open_allowed));
        check_value("door close", 0, int'(door_close_allowed));
    endtask

    task automatic test_single_request();
        test_name = "single request";
        press('0, floor_bit(7));
        check_value("panel lamp 7", int'(floor_bit(7)), int'(panel_lights));
        serve_request(7, 1'b1);
        press(floor_bit(3), '0);
        serve_request(3, 1'b0);
    endtask

    task automatic test_service_order();
        test_name = "order of service";
        press('0, floor_bit(9) | floor_bit(4) | floor_bit(6));
        check_value("panel lamps", int'(floor_bit(9) | floor_bit(4) | floor_bit(6)),
                    int'(panel_lights));
        repeat (4) @(negedge clock);
        press(floor_bit(2), '0);
        serve_request(4, 1'b1);
        serve_request(6, 1'b1);
        serve_request(9, 1'b1);
        serve_request(2, 1'b0);
    endtask

    task automatic test_ignored_presses();
        test_name = "ignored presses";
        press(floor_bit(2), floor_bit(2));
        check_value("call lights at current floor", 0, int'(call_lights));
        check_value("panel lights at current floor", 0, int'(panel_lights));
        press('0, floor_bit(5));
        press(floor_bit(5), floor_bit(5));
        press(floor_bit(10), floor_bit(10));
        serve_request(5, 1'b1);
        serve_request(10, 1'b1);
        expect_idle(12);
    endtask

    task automatic test_emergency_power();
        bit seen;
        test_name = "emergency and power";
        press('0, floor_bit(7) | floor_bit(9));
        wait_activate(seen);
        emergency_btn = 1'b1;
        @(negedge clock);
        check_value("activate in emergency", 0, int'(activate_elevator));
        press('0, floor_bit(3));
        check_value("panel lamp 3 in emergency", 0, int'(panel_lights[2]));
        expect_idle(5);
        // Emergency released in the same cycle that power goes away
        emergency_btn = 1'b0;
        power_switch  = 1'b0;
        @(negedge clock);
        check_value("call lights power off", 0, int'(call_lights));
        check_value("panel lights power off", 0, int'(panel_lights));
        check_value("target power off", 0, int'(target_floor));
        power_switch = 1'b1;
        expect_idle(12);
        check_value("panel lights power back", 0, int'(panel_lights));
    endtask

    task automatic test_doors();
        test_name = "doors";
        door_open_btn = 1'b1;
        @(negedge clock);
        check_value("open when stopped", 1, int'(door_open_allowed));
        check_value("close not pressed", 0, int'(door_close_allowed));
        elevator_moving = 1'b1;
        @(negedge clock);
        check_value("open while moving", 0, int'(door_open_allowed));
        elevator_moving = 1'b0;
        power_switch    = 1'b0;
        @(negedge clock);
        check_value("open power off", 0, int'(door_open_allowed));
        power_switch   = 1'b1;
        door_open_btn  = 1'b0;
        door_close_btn = 1'b1;
        @(negedge clock);
        check_value("close when stopped", 1, int'(door_close_allowed));
        check_value("open released", 0, int'(door_open_allowed));
        door_close_btn = 1'b0;
        @(negedge clock);
        check_value("close released", 0, int'(door_close_allowed));
    endtask

    initial begin
        clock           = 1'b0;
        reset_n         = 1'b0;
        call_buttons    = '0;
        panel_buttons   = '0;
        door_open_btn   = 1'b0;
        door_close_btn  = 1'b0;
        emergency_btn   = 1'b0;
        power_switch    = 1'b1;
        current_floor   = '0;
        elevator_moving = 1'b0;
        errors          = 0;
        checks          = 0;
        rng_state       = 32'd81;
        test_name       = "none";
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        test_reset_state();
        test_single_request();
        test_service_order();
        test_ignored_presses();
        test_emergency_power();
        test_doors();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the number of tests
    initial begin
        repeat (num_tests * test_bound) @(posedge clock);
        $display("Watchdog: run did not finish within %0d cycles", num_tests * test_bound);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hw/elevator_pkg.sv
hw/request_latch.sv
hw/request_queue.sv
hw/dispatch_control.sv
hw/floor_logic_top.sv
bench/floor_logic_properties.sv
bench/floor_logic_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module floor_logic_tb -o floor_logic_sim \
    && ./obj_dir/floor_logic_sim > sim.log 2>&1 \
    || echo "Build or simulation stopped early"
[ -f sim.log ] && cat sim.log
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
